// File: project.f
bram_pkg.sv
bram_cfg_apb.sv
bram_wr_decode.sv
bram_mem_1w1r.sv
bram_rd_result.sv
bram_tile.sv
tb_clk_gen.sv
bram_tile_tb.sv

// File: Bender.yml
package:
  name: bram_tile

sources:
  - bram_pkg.sv
  - bram_cfg_apb.sv
  - bram_wr_decode.sv
  - bram_mem_1w1r.sv
  - bram_rd_result.sv
  - bram_tile.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - bram_tile_tb.sv

// File: bram_tile_tb.sv
`timescale 1ns/10ps

module bram_tile_tb import bram_pkg::*; ();

  localparam int drive_dly     = 5;   // ns after the rising edge
  localparam int reset_timeout = 20;  // cycles
  localparam int apb_timeout   = 8;

  logic                  clk;
  logic                  arst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [apb_addr_w-1:0] paddr;
  logic [data_w-1:0]     pwdata;
  logic [data_w-1:0]     prdata;
  logic                  pready;
  logic                  pslverr;
  logic [addr_w-1:0]     wr_addr;
  logic [data_w-1:0]     wr_data;
  logic [addr_w-1:0]     rd_addr;
  logic [data_w-1:0]     rd_data;

  logic [data_w-1:0] shadow [0:depth-1];  // predicted array contents
  logic [data_w:0]   exp_q [$];           // {check, word} per issued read
  bram_cfg_t         tb_cfg;              // config as the DUT sees it
  logic              rd_chk;              // current read is checked
  logic              chk_vld;
  logic [data_w-1:0] chk_exp;
  integer            seed = 32'h941a;

  tb_clk_gen #(.period_ns(40)) u_clk (.clk(clk));

  bram_tile i_dut (.*);

  task automatic report_mismatch(input string name, input logic [data_w-1:0] exp,
                                 input logic [data_w-1:0] act);
    $display("MISMATCH %s expected %h actual %h", name, exp, act);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_error(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // checked at the falling edge, mid cycle
  rd_data_check: assert property (@(negedge clk) disable iff (!arst_n)
    chk_vld |-> rd_data == chk_exp)
    else report_mismatch("rd_data", chk_exp, rd_data);

  function automatic logic [data_w-1:0] rand_word(input logic en);
    logic [data_w-1:0] w;
    w = $random(seed);
    w[wr_en_bit] = en;  // dynamic write enable
    return w;
  endfunction

  function automatic logic [data_w-1:0] cfg_word(input bram_cfg_t c);
    return {{(data_w - cfg_w){1'b0}}, c};
  endfunction

  // byte lanes and data placement for one write
  task automatic shadow_write(input logic [addr_w-1:0] wa, input logic [data_w-1:0] wd);
    logic [1:0] ln;
    logic [3:0] mask;
    logic [7:0] b;
    ln = wd[wr_addr_msb_lsb +: 2];
    if (!(tb_cfg.always_wr || wd[wr_en_bit])) return;
    case (tb_cfg.wr_mode)
      w32:     mask = 4'b1111;
      w16:     mask = (ln == 2'd0) ? 4'b0011 : 4'b1100;
      default: mask = 4'b0001 << ln;
    endcase
    for (int i = 0; i < 4; i++) begin
      if (tb_cfg.wr_mode == w32) b = wd[8*i +: 8];
      else if (tb_cfg.wr_mode == w16) b = wd[8*(i%2) +: 8];  // halfword repeats
      else b = wd[7:0];
      if (mask[i]) shadow[wa][8*i +: 8] = b;
    end
  endtask

  // predict the read issued now, pick the one due at this cycle's check
  task automatic advance_cycle();
    logic [data_w-1:0] word;
    logic [1:0]        ln;
    int                lat;
    word = shadow[rd_addr];            // old contents on a collision
    ln   = wr_data[rd_addr_msb_lsb +: 2];
    case (tb_cfg.rd_mode)
      w16:     word[15:0] = ln[0] ? word[31:16] : word[15:0];
      w8:      word[7:0]  = word[8*ln +: 8];
      default: ;
    endcase
    exp_q.push_back({rd_chk, word});
    if (exp_q.size() > 4) exp_q.pop_front();
    lat = tb_cfg.out_reg ? 2 : 1;
    if (exp_q.size() > lat) {chk_vld, chk_exp} = exp_q[exp_q.size() - 1 - lat];
    else chk_vld = 1'b0;
    shadow_write(wr_addr, wr_data);
    @(posedge clk);
    #drive_dly;
  endtask

  task automatic fabric_access(input logic [addr_w-1:0] wa, input logic [data_w-1:0] wd,
                               input logic [addr_w-1:0] ra, input logic chk);
    wr_addr = wa;
    wr_data = wd;
    rd_addr = ra;
    rd_chk  = chk;
    advance_cycle();
  endtask

  // one apb transfer, checks pslverr and read data
  task automatic apb_check(input logic wr, input logic [apb_addr_w-1:0] addr,
                           input logic [data_w-1:0] wdata, input logic exp_err,
                           input logic [data_w-1:0] exp_rdata);
    int n;
    n       = 0;
    rd_chk  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    advance_cycle();                   // setup phase
    penable = 1'b1;
    #10;
    while (!pready) begin
      if (n >= apb_timeout) report_error("apb pready never came");
      advance_cycle();
      #10;
      n++;
    end
    assert (pslverr == exp_err) else report_mismatch("pslverr", 32'(exp_err), 32'(pslverr));
    if (!wr) assert (prdata == exp_rdata) else report_mismatch("prdata", exp_rdata, prdata);
    advance_cycle();                   // register loads here
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic set_cfg(input bram_cfg_t c);
    apb_check(1'b1, cfg_addr, cfg_word(c), 1'b0, '0);
    tb_cfg = c;
    apb_check(1'b0, cfg_addr, '0, 1'b0, cfg_word(c));  // readback
  endtask

  task automatic lane_write_sweep(input width_mode_e mode);
    bram_cfg_t         c;
    logic [addr_w-1:0] a;
    logic [data_w-1:0] wd;
    c         = cfg_reset;
    c.wr_mode = mode;
    set_cfg(c);
    for (int i = 0; i < 32; i++) begin
      a  = addr_w'($random(seed));
      wd = rand_word(1'b1);
      wd[wr_addr_msb_lsb +: 2] = 2'(i);  // every lane value
      fabric_access(a, wd, a, 1'b1);
      fabric_access('0, rand_word(1'b0), a, 1'b1);  // w32 view, other lanes intact
    end
  endtask

  task automatic lane_read_sweep(input width_mode_e mode);
    bram_cfg_t         c;
    logic [data_w-1:0] wd;
    c         = cfg_reset;
    c.rd_mode = mode;
    set_cfg(c);
    for (int i = 0; i < 32; i++) begin
      wd = rand_word(1'b0);
      wd[rd_addr_msb_lsb +: 2] = 2'(i);
      fabric_access('0, wd, addr_w'($random(seed)), 1'b1);
    end
  endtask

  initial begin : reset_gen
    arst_n = 1'b0;
    repeat (10) @(posedge clk);
    #drive_dly;
    arst_n = 1'b1;
  end

  initial begin : stimulus
    int                n;
    logic [addr_w-1:0] hold_addr [16];
    logic [data_w-1:0] hold_data [16];
    bram_cfg_t         c;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    wr_addr   = '0;
    wr_data   = '0;
    rd_addr   = '0;
    rd_chk    = 1'b0;
    chk_vld   = 1'b0;
    chk_exp   = '0;
    tb_cfg    = cfg_reset;
    n         = 0;
    while (arst_n !== 1'b1) begin      // x at time zero counts as reset
      if (n >= reset_timeout) report_error("reset was never released");
      @(posedge clk);
      n++;
    end
    #drive_dly;
    apb_check(1'b0, cfg_addr, '0, 1'b0, '0);       // reset value
    c = '{wr_mode: w16, rd_mode: w8, always_wr: 1'b1, out_reg: 1'b1};
    set_cfg(c);
    apb_check(1'b1, cfg_addr, 32'h30, 1'b1, '0);   // wr_mode reserved
    apb_check(1'b1, cfg_addr, 32'h0c, 1'b1, '0);   // rd_mode reserved
    apb_check(1'b1, 4'h8, 32'h1, 1'b1, '0);        // unmapped
    apb_check(1'b0, 4'h4, '0, 1'b1, '0);
    apb_check(1'b0, cfg_addr, '0, 1'b0, cfg_word(c));
    set_cfg(cfg_reset);
    for (int i = 0; i < depth; i++) fabric_access(addr_w'(i), rand_word(1'b1), '0, 1'b0);
    for (int i = 0; i < depth; i++) fabric_access('0, rand_word(1'b0), addr_w'(i), 1'b1);
    for (int i = 0; i < 32; i++) begin
      hold_addr[0] = addr_w'($random(seed));
      fabric_access(hold_addr[0], rand_word(1'b1), hold_addr[0], 1'b1);  // old word
      fabric_access('0, rand_word(1'b0), hold_addr[0], 1'b1);
    end
    lane_write_sweep(w16);
    lane_write_sweep(w8);
    lane_read_sweep(w16);
    lane_read_sweep(w8);
    // dynamic enable off in the data word, then forced by always_wr
    set_cfg(cfg_reset);
    for (int i = 0; i < 16; i++) begin
      hold_addr[i] = addr_w'($random(seed));
      hold_data[i] = rand_word(1'b0);
      fabric_access(hold_addr[i], hold_data[i], hold_addr[i], 1'b1);
      fabric_access(hold_addr[i], hold_data[i], hold_addr[i], 1'b1);
    end
    c           = cfg_reset;
    c.always_wr = 1'b1;
    set_cfg(c);
    for (int i = 0; i < 16; i++) begin
      fabric_access(hold_addr[i], hold_data[i], hold_addr[i], 1'b1);
      fabric_access(hold_addr[i], hold_data[i], hold_addr[i], 1'b1);
    end
    c         = cfg_reset;
    c.out_reg = 1'b1;
    set_cfg(c);
    for (int i = 0; i < 64; i++) fabric_access('0, rand_word(1'b0), addr_w'($random(seed)), 1'b1);
    for (int i = 0; i < 3; i++) fabric_access('0, rand_word(1'b0), '0, 1'b0);  // drain
    chk_vld = 1'b0;
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int period_ns = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;  // free running
  end

endmodule

// File: bram_tile.sv
`timescale 1ns/10ps

module bram_tile import bram_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  // apb config port
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [apb_addr_w-1:0] paddr,
  input  logic [data_w-1:0]     pwdata,
  output logic [data_w-1:0]     prdata,
  output logic                  pready,
  output logic                  pslverr,
  // fabric pins
  input  logic [addr_w-1:0]     wr_addr,
  input  logic [data_w-1:0]     wr_data,
  input  logic [addr_w-1:0]     rd_addr,
  output logic [data_w-1:0]     rd_data
);

  bram_cfg_t         cfg;       // live tile configuration
  bram_wr_req_t      wr_req;    // decoded write
  logic [data_w-1:0] raw_word;  // array output, full word

  bram_cfg_apb u_cfg (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .cfg     (cfg)
  );

  bram_wr_decode u_decode (
    .cfg     (cfg),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wr_req  (wr_req)
  );

  bram_mem_1w1r u_mem (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr_req   (wr_req),
    .rd_addr  (rd_addr),
    .raw_word (raw_word)
  );

  // read lane select rides in the write data word
  bram_rd_result u_result (
    .clk      (clk),
    .arst_n   (arst_n),
    .cfg      (cfg),
    .raw_word (raw_word),
    .rd_lane  (wr_data[rd_addr_msb_lsb +: 2]),
    .rd_data  (rd_data)
  );

endmodule

// File: bram_rd_result.sv
`timescale 1ns/10ps

module bram_rd_result import bram_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  bram_cfg_t         cfg,
  input  logic [data_w-1:0] raw_word,
  input  logic [1:0]        rd_lane,
  output logic [data_w-1:0] rd_data
);

  localparam int half_w = data_w / 2;
  localparam int byte_w = data_w / lanes;

  logic [1:0]        lane_q;    // lane select, in step with raw_word
  logic [data_w-1:0] narrow;    // lane-selected read
  logic [data_w-1:0] narrow_q;  // optional output stage

  // sampled on the same edge as rd_addr in the array
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lane_q <= '0;
    end else begin
      lane_q <= rd_lane;
    end
  end

  // narrow lanes land in the low bits, upper bits stay raw
  always_comb begin
    narrow = raw_word;
    case (cfg.rd_mode)
      w16: begin
        if (lane_q[0]) begin
          narrow[half_w-1:0] = raw_word[data_w-1:half_w];
        end else begin
          narrow[half_w-1:0] = raw_word[half_w-1:0];
        end
      end
      w8: begin
        narrow[byte_w-1:0] = raw_word[byte_w*lane_q +: byte_w];  // byte 0..3
      end
      default: begin
        narrow = raw_word;            // full word
      end
    endcase
  end

  // second read stage, adds one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      narrow_q <= '0;
    end else begin
      narrow_q <= narrow;
    end
  end

  assign rd_data = cfg.out_reg ? narrow_q : narrow;  // bypass when out_reg is 0

endmodule

// File: bram_mem_1w1r.sv
`timescale 1ns/10ps

module bram_mem_1w1r import bram_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  bram_wr_req_t      wr_req,
  input  logic [addr_w-1:0] rd_addr,
  output logic [data_w-1:0] raw_word
);

  localparam int byte_w = data_w / lanes;

  // behavioural array in place of the sram macro
  logic [data_w-1:0] mem [0:depth-1];

  // write port, byte lanes gated by the mask
  always_ff @(posedge clk) begin
    if (wr_req.en) begin
      for (int i = 0; i < lanes; i++) begin
        if (wr_req.mask[i]) begin
          mem[wr_req.addr][byte_w*i +: byte_w] <= wr_req.data[byte_w*i +: byte_w];
        end
      end
    end
  end

  // read port, every cycle
  // same address as a write returns the old word
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      raw_word <= '0;                 // reads zero until the first read
    end else begin
      raw_word <= mem[rd_addr];
    end
  end

endmodule

// File: bram_wr_decode.sv
`timescale 1ns/10ps

module bram_wr_decode import bram_pkg::*; (
  input  bram_cfg_t         cfg,
  input  logic [addr_w-1:0] wr_addr,
  input  logic [data_w-1:0] wr_data,
  output bram_wr_req_t      wr_req
);

  localparam int half_w = data_w / 2;
  localparam int byte_w = data_w / lanes;

  logic [1:0] lane;    // write lane select, upper address bits
  logic       dyn_en;  // per-cycle enable from the data word

  assign lane   = wr_data[wr_addr_msb_lsb +: 2];
  assign dyn_en = wr_data[wr_en_bit];

  always_comb begin
    wr_req      = '0;
    wr_req.addr = wr_addr;
    wr_req.en   = cfg.always_wr | dyn_en;   // always_wr overrides the data bit
    case (cfg.wr_mode)
      w32: begin
        wr_req.mask = '1;                   // whole word
        wr_req.data = wr_data;
      end
      w16: begin
        // lane 0 selects the low pair, anything else the high pair
        if (lane == 2'd0) begin
          wr_req.mask = 4'b0011;
        end else begin
          wr_req.mask = 4'b1100;
        end
        wr_req.data = {2{wr_data[half_w-1:0]}};  // mask picks the half
      end
      w8: begin
        wr_req.mask = 4'b0001 << lane;      // one lane
        wr_req.data = {lanes{wr_data[byte_w-1:0]}};
      end
      default: begin
        wr_req.mask = '0;                   // reserved, nothing written
      end
    endcase
  end

endmodule

// File: bram_cfg_apb.sv
`timescale 1ns/10ps

module bram_cfg_apb import bram_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [apb_addr_w-1:0] paddr,
  input  logic [data_w-1:0]     pwdata,
  output logic [data_w-1:0]     prdata,
  output logic                  pready,
  output logic                  pslverr,
  output bram_cfg_t             cfg
);

  logic      access;    // second cycle of a transfer
  logic      hit;       // address matches the config register
  logic      bad_mode;  // new value names a reserved width
  logic      wr_ok;     // legal write, update this edge
  bram_cfg_t cfg_new;   // pwdata viewed as config

  assign access   = psel & penable;
  assign hit      = (paddr == cfg_addr);
  assign cfg_new  = bram_cfg_t'(pwdata[cfg_w-1:0]);  // upper pwdata bits ignored

  // reserved width on either port is refused
  assign bad_mode = (cfg_new.wr_mode == reserved) | (cfg_new.rd_mode == reserved);
  assign wr_ok    = access & pwrite & hit & ~bad_mode;

  assign pready = 1'b1;  // no wait states

  // error is flagged in the access phase only
  always_comb begin
    pslverr = 1'b0;
    if (access) begin
      if (!hit) begin
        pslverr = 1'b1;               // unmapped address
      end else if (pwrite && bad_mode) begin
        pslverr = 1'b1;               // reserved mode, register kept
      end
    end
  end

  // readback, zero extended, zero elsewhere
  always_comb begin
    prdata = '0;
    if (psel && !pwrite && hit) begin
      prdata = {{(data_w - cfg_w){1'b0}}, cfg};
    end
  end

  // config register, takes effect from the next cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cfg <= cfg_reset;
    end else if (wr_ok) begin
      cfg <= cfg_new;
    end
  end

endmodule

// File: bram_pkg.sv
package bram_pkg;

  // word geometry of the tile
  localparam int addr_w = 8;             // 256 words
  localparam int data_w = 32;
  localparam int lanes  = 4;             // byte lanes per word
  localparam int depth  = 1 << addr_w;

  // fabric routing that rides inside wr_data
  localparam int wr_addr_msb_lsb = 16;   // wr_data[17:16] write lane select
  localparam int rd_addr_msb_lsb = 24;   // wr_data[25:24] read lane select
  localparam int wr_en_bit       = 20;   // dynamic write enable, 1 = write

  // port width selection, shared by write and read side
  typedef enum logic [1:0] {
    w32      = 2'd0,
    w16      = 2'd1,
    w8       = 2'd2,
    reserved = 2'd3                      // never stored, apb slave refuses it
  } width_mode_e;

  // six config bits, lsb first is out_reg
  typedef struct packed {
    width_mode_e wr_mode;                // bits 5:4
    width_mode_e rd_mode;                // bits 3:2
    logic        always_wr;              // bit 1, ignore dynamic enable
    logic        out_reg;                // bit 0, extra read register
  } bram_cfg_t;

  // decoded write, decode stage to memory
  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
    logic [lanes-1:0]  mask;             // one bit per byte lane
    logic [data_w-1:0] data;             // already lane aligned
  } bram_wr_req_t;

  // apb register map
  localparam int                    apb_addr_w = 4;
  localparam int                    cfg_w      = $bits(bram_cfg_t);
  localparam logic [apb_addr_w-1:0] cfg_addr   = '0;

  // full width both ports, dynamic enable, no output register
  localparam bram_cfg_t cfg_reset = '0;

endpackage
